//--- rtl/stereo_pkg.sv
package stereo_pkg;

  // row and column counter widths
  localparam int hcount_w = 11;
  localparam int vcount_w = 10;

  // pixels summed per block
  localparam int block_len = 4;

  // largest shift tried against the right image
  localparam int max_disparity = 3;

  // right history must cover the block plus every shift
  localparam int window_len = block_len + max_disparity;

  // 2-bit disparity to depth byte
  localparam int depth_shift = 6;

  // four 8-bit differences fit in 10 bits
  localparam int sad_w = 10;

  // luminance pixel from a camera branch
  typedef struct packed {
    logic [7:0]          luma;
    logic [hcount_w-1:0] hcount;
    logic [vcount_w-1:0] vcount;
  } luma_pixel_t;

  // depth result, counts follow the left pixel
  typedef struct packed {
    logic [7:0]          depth;
    logic [hcount_w-1:0] hcount;
    logic [vcount_w-1:0] vcount;
  } depth_pixel_t;

  // which half of rgb565 the next byte is
  typedef enum logic {
    first_byte,
    second_byte
  } byte_phase_e;

endpackage

//--- rtl/camera_capture.sv
`timescale 1ns/1ps

module camera_capture (
  input  logic                    clk_camera,
  input  logic                    reset,
  input  logic                    cam_pclk,
  input  logic                    cam_hsync,
  input  logic                    cam_vsync,
  input  logic [7:0]              cam_data,
  output logic                    pixel_valid,
  output stereo_pkg::luma_pixel_t pixel
);

  // bit 0 and 1 form the synchronizer, bit 2 is the edge reference
  logic [2:0] pclk_sync;
  logic [2:0] hsync_sync;
  logic [1:0] vsync_sync;
  logic [7:0] data_meta;
  logic [7:0] data_sync;

  logic pclk_rise;
  logic hsync_fall;
  logic byte_take;

  stereo_pkg::byte_phase_e phase;
  logic [7:0]  high_byte;
  logic [15:0] rgb565;
  logic [7:0]  r8;
  logic [7:0]  g8;
  logic [7:0]  b8;
  logic [10:0] luma_sum;

  logic [stereo_pkg::hcount_w-1:0] hcount;
  logic [stereo_pkg::vcount_w-1:0] vcount;

  always_ff @(posedge clk_camera) begin
    if (reset) begin
      pclk_sync  <= '0;
      hsync_sync <= '0;
      vsync_sync <= '0;
    end else begin
      pclk_sync  <= {pclk_sync[1:0], cam_pclk};
      hsync_sync <= {hsync_sync[1:0], cam_hsync};
      vsync_sync <= {vsync_sync[0], cam_vsync};
    end
  end

  // data takes the same two stages, so it lines up with pclk_sync[1]
  always_ff @(posedge clk_camera) begin
    data_meta <= cam_data;
    data_sync <= data_meta;
  end

  assign pclk_rise  = pclk_sync[1] & ~pclk_sync[2];
  assign hsync_fall = hsync_sync[2] & ~hsync_sync[1];

  // bytes only count inside a row and outside vsync
  assign byte_take = pclk_rise & hsync_sync[1] & ~vsync_sync[1];

  // high byte held, low byte still on the bus
  assign rgb565 = {high_byte, data_sync};
  assign r8 = {rgb565[15:11], 3'b000};
  assign g8 = {rgb565[10:5], 2'b00};
  assign b8 = {rgb565[4:0], 3'b000};

  // 2r + 4g + g + b, max 2004 so 11 bits
  assign luma_sum = {2'b00, r8, 1'b0} + {1'b0, g8, 2'b00} + {3'b000, g8} + {3'b000, b8};

  // phase fsm and counters
  always_ff @(posedge clk_camera) begin
    if (reset) begin
      phase       <= stereo_pkg::first_byte;
      hcount      <= '0;
      vcount      <= '0;
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= 1'b0;
      if (vsync_sync[1]) begin
        // frame boundary
        phase  <= stereo_pkg::first_byte;
        hcount <= '0;
        vcount <= '0;
      end else if (hsync_fall) begin
        // end of row
        phase  <= stereo_pkg::first_byte;
        hcount <= '0;
        vcount <= vcount + 1'b1;
      end else if (byte_take) begin
        case (phase)
          stereo_pkg::first_byte: begin
            phase <= stereo_pkg::second_byte;
          end
          stereo_pkg::second_byte: begin
            phase       <= stereo_pkg::first_byte;
            pixel_valid <= 1'b1;
            hcount      <= hcount + 1'b1;
          end
          default: phase <= stereo_pkg::first_byte;
        endcase
      end
    end
  end

  // payload, counts taken before the increment
  always_ff @(posedge clk_camera) begin
    if (byte_take && phase == stereo_pkg::first_byte) begin
      high_byte <= data_sync;
    end
    if (byte_take && phase == stereo_pkg::second_byte) begin
      pixel.luma   <= luma_sum[10:3];
      pixel.hcount <= hcount;
      pixel.vcount <= vcount;
    end
  end

endmodule

//--- rtl/pixel_queue.sv
`timescale 1ns/1ps

module pixel_queue #(
  parameter int depth = 8
) (
  input  logic                    clk_camera,
  input  logic                    reset,
  input  logic                    in_valid,
  input  stereo_pkg::luma_pixel_t in_pixel,
  output logic                    out_valid,
  input  logic                    out_ready,
  output stereo_pkg::luma_pixel_t out_pixel,
  output logic                    overflow
);

  stereo_pkg::luma_pixel_t mem [depth];

  logic [$clog2(depth)-1:0] wr_ptr;
  logic [$clog2(depth)-1:0] rd_ptr;
  logic [$clog2(depth):0]   count;
  logic                     full;
  logic                     do_write;
  logic                     do_read;

  // top count bit only set at depth entries
  assign full      = count[$clog2(depth)];
  assign out_valid = (count != '0);
  assign out_pixel = mem[rd_ptr];

  // camera can't stall, so a write into a full queue is lost
  assign do_write = in_valid & ~full;
  assign do_read  = out_valid & out_ready;

  always_ff @(posedge clk_camera) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      // pointers wrap on their own
      if (do_write) wr_ptr <= wr_ptr + 1'b1;
      if (do_read) rd_ptr <= rd_ptr + 1'b1;
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // sticky until reset
      if (in_valid && full) overflow <= 1'b1;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (do_write) mem[wr_ptr] <= in_pixel;
  end

endmodule

//--- rtl/disparity_search.sv
`timescale 1ns/1ps

module disparity_search (
  input  logic                     clk_camera,
  input  logic                     reset,
  input  logic                     left_valid,
  input  stereo_pkg::luma_pixel_t  left_pixel,
  output logic                     left_ready,
  input  logic                     right_valid,
  input  stereo_pkg::luma_pixel_t  right_pixel,
  output logic                     right_ready,
  output logic                     depth_valid,
  input  logic                     depth_ready,
  output stereo_pkg::depth_pixel_t depth_out
);

  // index 0 is the newest pixel
  // registered history leaves out the incoming pixel
  logic [7:0] left_win   [stereo_pkg::block_len-1];
  logic [7:0] right_win  [stereo_pkg::window_len-1];
  logic [7:0] left_next  [stereo_pkg::block_len];
  logic [7:0] right_next [stereo_pkg::window_len];
  logic [stereo_pkg::sad_w-1:0] sad_next [stereo_pkg::max_disparity+1];

  logic advance;
  logic accept;
  logic row_start;

  // stage one
  logic                            s1_valid;
  logic [stereo_pkg::sad_w-1:0]    s1_sad [stereo_pkg::max_disparity+1];
  logic [stereo_pkg::hcount_w-1:0] s1_hcount;
  logic [stereo_pkg::vcount_w-1:0] s1_vcount;

  // stage two select
  logic [7:0]                   best_d;
  logic [stereo_pkg::sad_w-1:0] best_sad;

  function automatic logic [7:0] abs_diff(input logic [7:0] a, input logic [7:0] b);
    return (a > b) ? (a - b) : (b - a);
  endfunction

  // whole pipe moves together and holds while the output is stalled
  assign advance = ~depth_valid | depth_ready;

  // take one pixel from each side together so the streams stay paired
  assign accept      = left_valid & right_valid & advance;
  assign left_ready  = accept;
  assign right_ready = accept;

  assign row_start = (left_pixel.hcount == '0);

  // shifted windows including the incoming pair
  always_comb begin
    left_next[0] = left_pixel.luma;
    for (int k = 1; k < stereo_pkg::block_len; k++) begin
      left_next[k] = row_start ? 8'h00 : left_win[k-1];
    end
    right_next[0] = right_pixel.luma;
    for (int k = 1; k < stereo_pkg::window_len; k++) begin
      right_next[k] = row_start ? 8'h00 : right_win[k-1];
    end
  end

  // one sad per shift with right pixel k+d sitting d columns further left
  always_comb begin
    for (int d = 0; d <= stereo_pkg::max_disparity; d++) begin
      sad_next[d] = '0;
      for (int k = 0; k < stereo_pkg::block_len; k++) begin
        sad_next[d] = sad_next[d]
                    + {{(stereo_pkg::sad_w-8){1'b0}}, abs_diff(left_next[k], right_next[k+d])};
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= accept;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (accept) begin
      // oldest entry of each window drops out here
      for (int k = 0; k < stereo_pkg::block_len - 1; k++) begin
        left_win[k] <= left_next[k];
      end
      for (int k = 0; k < stereo_pkg::window_len - 1; k++) begin
        right_win[k] <= right_next[k];
      end
      s1_sad    <= sad_next;
      s1_hcount <= left_pixel.hcount;
      s1_vcount <= left_pixel.vcount;
    end
  end

  // strict compare keeps the smaller d on a tie
  always_comb begin
    best_d   = '0;
    best_sad = s1_sad[0];
    for (int d = 1; d <= stereo_pkg::max_disparity; d++) begin
      if (s1_sad[d] < best_sad) begin
        best_d   = 8'(d);
        best_sad = s1_sad[d];
      end
    end
    // right history not yet full near the row start
    if (s1_hcount < (stereo_pkg::window_len - 1)) begin
      best_d = '0;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (reset) begin
      depth_valid <= 1'b0;
    end else if (advance) begin
      depth_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (advance && s1_valid) begin
      depth_out.depth  <= best_d << stereo_pkg::depth_shift;
      depth_out.hcount <= s1_hcount;
      depth_out.vcount <= s1_vcount;
    end
  end

endmodule

//--- rtl/stereo_depth_top.sv
`timescale 1ns/1ps

module stereo_depth_top (
  input  logic                     clk_camera,
  input  logic                     reset,
  input  logic                     left_cam_pclk,
  input  logic                     left_cam_hsync,
  input  logic                     left_cam_vsync,
  input  logic [7:0]               left_cam_data,
  input  logic                     right_cam_pclk,
  input  logic                     right_cam_hsync,
  input  logic                     right_cam_vsync,
  input  logic [7:0]               right_cam_data,
  input  logic                     depth_ready,
  output logic                     depth_valid,
  output stereo_pkg::depth_pixel_t depth_out,
  output logic                     left_overflow,
  output logic                     right_overflow
);

  // capture to queue
  logic                    left_capture_valid;
  stereo_pkg::luma_pixel_t left_capture_pixel;
  logic                    right_capture_valid;
  stereo_pkg::luma_pixel_t right_capture_pixel;

  // queue to search
  logic                    left_queue_valid;
  logic                    left_queue_ready;
  stereo_pkg::luma_pixel_t left_queue_pixel;
  logic                    right_queue_valid;
  logic                    right_queue_ready;
  stereo_pkg::luma_pixel_t right_queue_pixel;

  // left branch
  camera_capture left_capture (
    .clk_camera (clk_camera),
    .reset      (reset),
    .cam_pclk   (left_cam_pclk),
    .cam_hsync  (left_cam_hsync),
    .cam_vsync  (left_cam_vsync),
    .cam_data   (left_cam_data),
    .pixel_valid(left_capture_valid),
    .pixel      (left_capture_pixel)
  );

  pixel_queue left_queue (
    .clk_camera(clk_camera),
    .reset     (reset),
    .in_valid  (left_capture_valid),
    .in_pixel  (left_capture_pixel),
    .out_valid (left_queue_valid),
    .out_ready (left_queue_ready),
    .out_pixel (left_queue_pixel),
    .overflow  (left_overflow)
  );

  // right branch
  camera_capture right_capture (
    .clk_camera (clk_camera),
    .reset      (reset),
    .cam_pclk   (right_cam_pclk),
    .cam_hsync  (right_cam_hsync),
    .cam_vsync  (right_cam_vsync),
    .cam_data   (right_cam_data),
    .pixel_valid(right_capture_valid),
    .pixel      (right_capture_pixel)
  );

  pixel_queue right_queue (
    .clk_camera(clk_camera),
    .reset     (reset),
    .in_valid  (right_capture_valid),
    .in_pixel  (right_capture_pixel),
    .out_valid (right_queue_valid),
    .out_ready (right_queue_ready),
    .out_pixel (right_queue_pixel),
    .overflow  (right_overflow)
  );

  // pairs both queues and drives the depth output
  disparity_search depth_search (
    .clk_camera (clk_camera),
    .reset      (reset),
    .left_valid (left_queue_valid),
    .left_pixel (left_queue_pixel),
    .left_ready (left_queue_ready),
    .right_valid(right_queue_valid),
    .right_pixel(right_queue_pixel),
    .right_ready(right_queue_ready),
    .depth_valid(depth_valid),
    .depth_ready(depth_ready),
    .depth_out  (depth_out)
  );

endmodule

//--- bench/stereo_model.svh
`ifndef STEREO_MODEL_SVH
`define STEREO_MODEL_SVH

// luminance of one rgb565 pixel
// channels widened to 8 bits, then (2r + 5g + b) / 8
function automatic logic [7:0] luma_of(input logic [15:0] rgb);
  int r8;
  int g8;
  int b8;
  int sum;
  r8 = int'(rgb[15:11]) * 8;
  g8 = int'(rgb[10:5]) * 4;
  b8 = int'(rgb[4:0]) * 8;
  sum = (2 * r8 + 5 * g8 + b8) / 8;
  return sum[7:0];
endfunction

// expected depth byte at row v, column h of the current image pair
function automatic logic [7:0] model_depth(input int v, input int h);
  int sad;
  int diff;
  int best_sad;
  int best_d;
  best_d   = 0;
  best_sad = -1;
  // right history incomplete this close to the row start
  if (h < stereo_pkg::window_len - 1) return 8'h00;
  for (int d = 0; d <= stereo_pkg::max_disparity; d++) begin
    sad = 0;
    for (int k = 0; k < stereo_pkg::block_len; k++) begin
      diff = int'(luma_of(left_rgb[v][h-k])) - int'(luma_of(right_rgb[v][h-k-d]));
      if (diff < 0) diff = -diff;
      sad = sad + diff;
    end
    // strict less than, so the smaller d survives a tie
    if (best_sad < 0 || sad < best_sad) begin
      best_sad = sad;
      best_d   = d;
    end
  end
  return 8'(best_d << stereo_pkg::depth_shift);
endfunction

// one expected entry per pixel, row-major
task automatic queue_expected_frame();
  stereo_pkg::depth_pixel_t entry;
  for (int v = 0; v < frame_rows; v++) begin
    for (int h = 0; h < row_len; h++) begin
      entry.depth  = model_depth(v, h);
      entry.hcount = h[stereo_pkg::hcount_w-1:0];
      entry.vcount = v[stereo_pkg::vcount_w-1:0];
      exp_q.push_back(entry);
    end
  end
endtask

`endif

//--- bench/tb_stereo_depth.sv
`timescale 1ns/1ps

module tb_stereo_depth;

  localparam int row_len    = 16;
  localparam int frame_rows = 4;
  // vsync takes 3 pclk periods and a row 2 per pixel plus 2 blank, at 8 clocks each
  localparam int frame_cycles = 8 * (3 + frame_rows * (2 * row_len + 2));
  localparam int frames_sent  = 6;
  localparam int cycle_limit  = 2 * frame_cycles * frames_sent;

  logic                     clk_camera = 1'b0;
  logic                     reset;
  logic                     left_cam_pclk;
  logic                     left_cam_hsync;
  logic                     left_cam_vsync;
  logic [7:0]               left_cam_data;
  logic                     right_cam_pclk;
  logic                     right_cam_hsync;
  logic                     right_cam_vsync;
  logic [7:0]               right_cam_data;
  logic                     depth_ready = 1'b1;
  logic                     depth_valid;
  stereo_pkg::depth_pixel_t depth_out;
  logic                     left_overflow;
  logic                     right_overflow;

  // current image pair and the expected output stream
  logic [15:0]              left_rgb  [frame_rows][row_len];
  logic [15:0]              right_rgb [frame_rows][row_len];
  stereo_pkg::depth_pixel_t exp_q [$];
  stereo_pkg::depth_pixel_t expected;
  logic                     ready_pattern [256];

  // sink ready mode 0 always high, 1 from the pattern, 2 held low
  int   ready_mode = 0;
  logic loose_check = 1'b0;
  logic shift_check = 1'b0;
  int   cycle_count = 0;
  int   check_errors = 0;
  int   errors_at_start = 0;
  int   outputs_seen = 0;
  int   tests_failed = 0;
  int   idle;

  `include "stereo_model.svh"

  stereo_depth_top stereo_depth_top_inst (
    .clk_camera     (clk_camera),
    .reset          (reset),
    .left_cam_pclk  (left_cam_pclk),
    .left_cam_hsync (left_cam_hsync),
    .left_cam_vsync (left_cam_vsync),
    .left_cam_data  (left_cam_data),
    .right_cam_pclk (right_cam_pclk),
    .right_cam_hsync(right_cam_hsync),
    .right_cam_vsync(right_cam_vsync),
    .right_cam_data (right_cam_data),
    .depth_ready    (depth_ready),
    .depth_valid    (depth_valid),
    .depth_out      (depth_out),
    .left_overflow  (left_overflow),
    .right_overflow (right_overflow)
  );

  always #2 clk_camera = ~clk_camera;

  always @(posedge clk_camera) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: no finish within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // one pclk period on both cameras with the byte set up while pclk is low
  task automatic pclk_period(input logic [7:0] left_byte, input logic [7:0] right_byte);
    left_cam_data  = left_byte;
    right_cam_data = right_byte;
    left_cam_pclk  = 1'b0;
    right_cam_pclk = 1'b0;
    repeat (4) @(negedge clk_camera);
    left_cam_pclk  = 1'b1;
    right_cam_pclk = 1'b1;
    repeat (4) @(negedge clk_camera);
  endtask

  // vsync pulse, then rows of high byte / low byte pairs
  task automatic send_frames(input int n_frames);
    for (int f = 0; f < n_frames; f++) begin
      left_cam_vsync  = 1'b1;
      right_cam_vsync = 1'b1;
      repeat (2) pclk_period(8'h00, 8'h00);
      left_cam_vsync  = 1'b0;
      right_cam_vsync = 1'b0;
      pclk_period(8'h00, 8'h00);
      for (int v = 0; v < frame_rows; v++) begin
        left_cam_hsync  = 1'b1;
        right_cam_hsync = 1'b1;
        for (int h = 0; h < row_len; h++) begin
          pclk_period(left_rgb[v][h][15:8], right_rgb[v][h][15:8]);
          pclk_period(left_rgb[v][h][7:0], right_rgb[v][h][7:0]);
        end
        // falling hsync ends the row
        left_cam_hsync  = 1'b0;
        right_cam_hsync = 1'b0;
        repeat (2) pclk_period(8'h00, 8'h00);
      end
    end
  endtask

  // kind 0 identical, 1 right sees each feature two columns earlier, 2 independent
  task automatic fill_images(input int kind);
    logic [31:0] r;
    for (int v = 0; v < frame_rows; v++) begin
      for (int h = 0; h < row_len; h++) begin
        r = $urandom;
        left_rgb[v][h] = r[15:0];
        r = $urandom;
        right_rgb[v][h] = r[15:0];
      end
    end
    for (int v = 0; v < frame_rows; v++) begin
      for (int h = 0; h < row_len; h++) begin
        if (kind == 0) right_rgb[v][h] = left_rgb[v][h];
        // row tail keeps its random pixels
        if (kind == 1 && h + 2 < row_len) right_rgb[v][h] = left_rgb[v][h+2];
      end
    end
  endtask

  task automatic check_exact();
    if (exp_q.size() == 0) begin
      $display("depth output at hcount %0d vcount %0d arrived with nothing expected",
               depth_out.hcount, depth_out.vcount);
      check_errors++;
    end else begin
      expected = exp_q.pop_front();
      if (depth_out.depth !== expected.depth) begin
        $display("CHECK FAILED depth_out.depth got 0x%02h expected 0x%02h at hcount %0d vcount %0d",
                 depth_out.depth, expected.depth, expected.hcount, expected.vcount);
        check_errors++;
      end
      if (depth_out.hcount !== expected.hcount) begin
        $display("CHECK FAILED depth_out.hcount got 0x%03h expected 0x%03h",
                 depth_out.hcount, expected.hcount);
        check_errors++;
      end
      if (depth_out.vcount !== expected.vcount) begin
        $display("CHECK FAILED depth_out.vcount got 0x%03h expected 0x%03h",
                 depth_out.vcount, expected.vcount);
        check_errors++;
      end
      // offset of two columns once the window is full
      if (shift_check && expected.hcount >= stereo_pkg::window_len - 1
          && depth_out.depth !== 8'h80) begin
        $display("CHECK FAILED depth_out.depth got 0x%02h expected 0x80 at hcount %0d",
                 depth_out.depth, expected.hcount);
        check_errors++;
      end
    end
  endtask

  // drops only cut the row tail, so each output keeps the model depth of its position
  task automatic check_loose();
    if (depth_out.hcount >= row_len || depth_out.vcount >= frame_rows) begin
      $display("depth output at hcount %0d vcount %0d has no model entry",
               depth_out.hcount, depth_out.vcount);
      check_errors++;
    end else begin
      expected.depth = model_depth(depth_out.vcount, depth_out.hcount);
      if (depth_out.depth !== expected.depth) begin
        $display("CHECK FAILED depth_out.depth got 0x%02h expected 0x%02h at hcount %0d vcount %0d",
                 depth_out.depth, expected.depth, depth_out.hcount, depth_out.vcount);
        check_errors++;
      end
    end
  endtask

  // output sink sets ready and takes the transfer on the same falling edge
  always @(negedge clk_camera) begin
    case (ready_mode)
      0:       depth_ready = 1'b1;
      1:       depth_ready = ready_pattern[cycle_count % 256];
      default: depth_ready = 1'b0;
    endcase
    if (!reset && depth_valid && depth_ready) begin
      outputs_seen++;
      if (loose_check) check_loose();
      else check_exact();
    end
  end

  task automatic check_overflow(input logic expect_set);
    if (left_overflow !== expect_set) begin
      $display("CHECK FAILED left_overflow got 0x%0h expected 0x%0h", left_overflow, expect_set);
      check_errors++;
    end
    if (right_overflow !== expect_set) begin
      $display("CHECK FAILED right_overflow got 0x%0h expected 0x%0h", right_overflow, expect_set);
      check_errors++;
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk_camera);
    // room for any extra output
    repeat (16) @(negedge clk_camera);
  endtask

  task automatic start_test();
    errors_at_start = check_errors;
    outputs_seen    = 0;
  endtask

  task automatic report_test(input int num, input string name);
    if (check_errors == errors_at_start) begin
      $display("test %0d %s: ok, %0d outputs", num, name, outputs_seen);
    end else begin
      $display("test %0d %s: %0d errors, %0d outputs", num, name,
               check_errors - errors_at_start, outputs_seen);
      tests_failed++;
    end
  endtask

  initial begin
    void'($urandom(4));
    reset           = 1'b1;
    left_cam_pclk   = 1'b0;
    left_cam_hsync  = 1'b0;
    left_cam_vsync  = 1'b0;
    left_cam_data   = 8'h00;
    right_cam_pclk  = 1'b0;
    right_cam_hsync = 1'b0;
    right_cam_vsync = 1'b0;
    right_cam_data  = 8'h00;
    // ready high three cycles in four
    for (int i = 0; i < 256; i++) ready_pattern[i] = (($urandom % 4) != 0);
    repeat (4) @(negedge clk_camera);
    reset = 1'b0;

    start_test();
    fill_images(0);
    queue_expected_frame();
    send_frames(1);
    wait_drain();
    report_test(1, "identical images");

    start_test();
    fill_images(1);
    shift_check = 1'b1;
    queue_expected_frame();
    send_frames(1);
    wait_drain();
    shift_check = 1'b0;
    report_test(2, "two column offset");

    start_test();
    fill_images(2);
    queue_expected_frame();
    send_frames(1);
    wait_drain();
    report_test(3, "independent images");

    // same images again under random back-pressure
    start_test();
    ready_mode = 1;
    queue_expected_frame();
    send_frames(1);
    wait_drain();
    ready_mode = 0;
    check_overflow(1'b0);
    report_test(4, "random depth_ready");

    start_test();
    ready_mode  = 2;
    loose_check = 1'b1;
    send_frames(2);
    ready_mode = 0;
    idle = 0;
    while (idle < 32) begin
      @(negedge clk_camera);
      if (depth_valid) idle = 0;
      else idle++;
    end
    check_overflow(1'b1);
    if (outputs_seen == 0) begin
      $display("no depth output arrived after the stall was released");
      check_errors++;
    end
    report_test(5, "stalled output overflow");

    $display("tests run 5, tests failed %0d, check failures %0d", tests_failed, check_errors);
    if (check_errors == 0 && tests_failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+bench
rtl/stereo_pkg.sv
rtl/camera_capture.sv
rtl/pixel_queue.sv
rtl/disparity_search.sv
rtl/stereo_depth_top.sv
bench/tb_stereo_depth.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f vlog.f \
    --top-module tb_stereo_depth --Mdir obj_dir -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
exit 1
